//--- sdram_cmd.f
hw/sdram_cmd_pkg.sv
hw/page_match.sv
hw/timing_tracker.sv
hw/command_issue.sv
hw/sdram_cmd_top.sv
testbench/sdram_cmd_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the SDRAM command scheduler testbench with Verilator and runs it
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=build
LOG=sim.log

rm -rf "$BUILD_DIR"
verilator --binary --timing --assert \
  --top-module sdram_cmd_tb \
  --Mdir "$BUILD_DIR" -o sdram_cmd_sim \
  -f sdram_cmd.f

"./$BUILD_DIR/sdram_cmd_sim" | tee "$LOG"

if grep -q "ERRORS FOUND" "$LOG"; then
  echo "Simulation failed, see $LOG"
  exit 1
fi
echo "Simulation passed"

//--- testbench/sdram_cmd_tb.sv
`timescale 1ns/1ns

module sdram_cmd_tb
  import sdram_cmd_pkg::*;
();

  localparam int ACCESSES_PER_PORT = 40;
  localparam int REFRESH_GAP       = 97;   // Cycles between strobe toggles
  localparam int REFRESH_LIMIT     = 60;
  localparam int CYCLE_LIMIT       = 40 * 2 * ACCESSES_PER_PORT + 400;

  logic                   INPUT_CLK;
  logic                   RST;
  logic                   refresh_strobe;
  logic                   req_rand;
  logic                   we_rand;
  logic                   req_bulk;
  logic                   we_bulk;
  logic [HOST_ADDR_W-1:0] addr_rand;
  logic [HOST_ADDR_W-1:0] addr_bulk;
  logic                   grant_rand;
  logic                   grant_bulk;
  cmd_t                   sd_cmd;
  logic [SD_ADDR_W-1:0]   sd_addr;
  logic [BANK_W-1:0]      sd_bank;

  // Reference model of the open page and refresh bookkeeping
  logic                   rst_low_q = 1'b0;
  logic                   prev_busy;
  logic                   model_open;
  logic [ROW_W-1:0]       model_row;
  logic [BANK_W-1:0]      model_bank;
  int                     since_actv;
  logic                   refresh_pending;
  logic                   strobe_last;
  int                     refresh_age;

  logic                   quiet_phase = 1'b0;
  logic [31:0]            rng_state;
  int                     error_count = 0;
  int                     accesses_driven = 0;
  int                     grants_seen;
  int                     cycle_count = 0;
  int                     test_count = 0;

  logic                   grant_any;
  logic [HOST_ADDR_W-1:0] served_addr;
  cmd_t                   served_cmd;
  logic [ROW_W-1:0]       actv_row;

  assign grant_any   = grant_rand || grant_bulk;
  assign served_addr = grant_bulk ? addr_bulk : addr_rand;
  assign served_cmd  = (grant_bulk ? we_bulk : we_rand) ? CMD_WRTE : CMD_READ;
  assign actv_row    = {sd_addr[12:11], sd_addr[9:0]};  // A10 skipped

  sdram_cmd_top u_dut (
    .INPUT_CLK      (INPUT_CLK),
    .RST            (RST),
    .refresh_strobe (refresh_strobe),
    .req_rand       (req_rand),
    .we_rand        (we_rand),
    .req_bulk       (req_bulk),
    .we_bulk        (we_bulk),
    .addr_rand      (addr_rand),
    .addr_bulk      (addr_bulk),
    .grant_rand     (grant_rand),
    .grant_bulk     (grant_bulk),
    .sd_cmd         (sd_cmd),
    .sd_addr        (sd_addr),
    .sd_bank        (sd_bank)
  );

  initial
  begin
    INPUT_CLK = 1'b0;
    forever #5 INPUT_CLK = ~INPUT_CLK;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [PAGE_W-1:0] page_of(input logic [HOST_ADDR_W-1:0] a);
    return a[HOST_ADDR_W-1:COL_W];  // Row and bank
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    error_count++;
    $display("Error: %0s is 0x%0h, expected 0x%0h at %0t ns", name, got, exp, $time);
  endtask

  task automatic report_violation(input string what);
    error_count++;
    $display("%0s at %0t ns", what, $time);
  endtask

  // Four rows per bank, and half the time the same page again
  task automatic next_access(inout logic [HOST_ADDR_W-1:0] addr, output logic we);
    logic [31:0] r;
    rng_state = xorshift32(rng_state);
    r         = rng_state;
    if (r[0])
      addr = {addr[HOST_ADDR_W-1:COL_W], r[27:16]};
    else
      addr = {r[2:1], 10'h155, r[4:3], r[27:16]};
    we = r[5];
    accesses_driven++;
  endtask

  // ------------------------------
  // Model update
  // ------------------------------
  always @(posedge INPUT_CLK)
  begin
    rst_low_q <= !RST;
  end

  always_ff @(posedge INPUT_CLK)
  begin
    if (!RST)
    begin
      prev_busy       <= 1'b0;
      model_open      <= 1'b0;
      model_row       <= '0;
      model_bank      <= '0;
      since_actv      <= 0;
      refresh_pending <= 1'b0;
      refresh_age     <= 0;
      strobe_last     <= 1'b0;
      grants_seen     <= 0;
    end
    else
    begin
      prev_busy   <= sd_cmd != CMD_NOOP;
      strobe_last <= refresh_strobe;
      grants_seen <= grants_seen + int'(grant_rand) + int'(grant_bulk);
      since_actv  <= since_actv + 1;
      if (sd_cmd == CMD_ACTV)
      begin
        model_open <= 1'b1;
        model_row  <= actv_row;
        model_bank <= sd_bank;
        since_actv <= 1;
      end
      if (sd_cmd == CMD_PRCH)
        model_open <= 1'b0;
      if (sd_cmd == CMD_ARSR)
      begin
        refresh_pending <= 1'b0;
        refresh_age     <= 0;
      end
      else if (refresh_strobe != strobe_last)
      begin
        refresh_pending <= 1'b1;  // New toggle
        refresh_age     <= 0;
      end
      else if (refresh_pending)
        refresh_age <= refresh_age + 1;
    end
  end

  // ------------------------------
  // Checks, sampled mid-cycle
  // ------------------------------
  assert property (@(negedge INPUT_CLK) rst_low_q |-> sd_cmd == CMD_NOOP)
    else report_mismatch("sd_cmd", 32'($sampled(sd_cmd)), 32'(CMD_NOOP));
  assert property (@(negedge INPUT_CLK) rst_low_q |-> sd_addr == PRCH_ALL_ADDR)
    else report_mismatch("sd_addr", 32'($sampled(sd_addr)), 32'(PRCH_ALL_ADDR));
  assert property (@(negedge INPUT_CLK) (rst_low_q || quiet_phase) |-> !grant_any)
    else report_violation("Grant raised during or right after reset");
  assert property (@(negedge INPUT_CLK) quiet_phase |-> sd_cmd == CMD_NOOP)
    else report_violation("Command issued with no request and no refresh pending");

  assert property (@(negedge INPUT_CLK) disable iff (!RST) prev_busy |-> sd_cmd == CMD_NOOP)
    else report_violation("Command issued in the cycle right after another command");

  assert property (@(negedge INPUT_CLK) disable iff (!RST) !(grant_rand && grant_bulk))
    else report_violation("Both ports granted in the same cycle");
  assert property (@(negedge INPUT_CLK) disable iff (!RST) grant_any |-> sd_cmd == served_cmd)
    else report_mismatch("sd_cmd", 32'($sampled(sd_cmd)), 32'($sampled(served_cmd)));
  assert property (@(negedge INPUT_CLK) disable iff (!RST)
                   grant_any |-> sd_bank == served_addr[COL_W+BANK_W-1:COL_W])
    else report_mismatch("sd_bank", 32'($sampled(sd_bank)),
                         32'($sampled(served_addr[COL_W+BANK_W-1:COL_W])));
  assert property (@(negedge INPUT_CLK) disable iff (!RST)
                   grant_any |-> sd_addr == {served_addr[COL_W-1:0], 1'b0})
    else report_mismatch("sd_addr", 32'($sampled(sd_addr)),
                         32'($sampled({served_addr[COL_W-1:0], 1'b0})));
  assert property (@(negedge INPUT_CLK) disable iff (!RST)
                   grant_any |-> model_open && {model_row, model_bank} == page_of(served_addr))
    else report_violation("Access granted while its row is not open in its bank");

  assert property (@(negedge INPUT_CLK) disable iff (!RST) sd_cmd == CMD_ACTV |-> !model_open)
    else report_violation("ACTV issued while a page is still open");
  assert property (@(negedge INPUT_CLK) disable iff (!RST) sd_cmd == CMD_ACTV |-> !sd_addr[10])
    else report_mismatch("sd_addr[10]", 32'($sampled(sd_addr[10])), 32'(0));
  assert property (@(negedge INPUT_CLK) disable iff (!RST)
                   sd_cmd == CMD_ACTV |->
                   (req_rand && {actv_row, sd_bank} == page_of(addr_rand)) ||
                   (req_bulk && {actv_row, sd_bank} == page_of(addr_bulk)))
    else report_violation("ACTV opened a page that no port requests");
  assert property (@(negedge INPUT_CLK) disable iff (!RST)
                   sd_cmd == CMD_PRCH |-> sd_addr == PRCH_ALL_ADDR)
    else report_mismatch("sd_addr", 32'($sampled(sd_addr)), 32'(PRCH_ALL_ADDR));
  assert property (@(negedge INPUT_CLK) disable iff (!RST)
                   (sd_cmd == CMD_READ || sd_cmd == CMD_WRTE) |-> model_open && since_actv >= 4)
    else report_violation("READ or WRTE with no open page or too soon after ACTV");

  assert property (@(negedge INPUT_CLK) disable iff (!RST) refresh_age != REFRESH_LIMIT)
    else report_violation("No ARSR within the bound after a refresh toggle");
  assert property (@(negedge INPUT_CLK) disable iff (!RST)
                   sd_cmd == CMD_ARSR |-> !model_open && refresh_pending)
    else report_violation("ARSR issued with a page open or no refresh pending");

  // ------------------------------
  // Stimulus
  // ------------------------------
  task automatic finish_test(input string name, input int errors_before);
    test_count++;
    $display("Test %0s finished with %0d errors", name, error_count - errors_before);
  endtask

  task automatic reset_idle();
    quiet_phase = 1'b1;
    repeat (12) @(negedge INPUT_CLK);
    quiet_phase = 1'b0;
  endtask

  task automatic run_traffic(input int per_port);
    int left_rand;
    int left_bulk;
    int cycles;
    left_rand = per_port;
    left_bulk = per_port;
    cycles    = 0;
    @(negedge INPUT_CLK);
    next_access(addr_rand, we_rand);
    next_access(addr_bulk, we_bulk);
    req_rand = 1'b1;
    req_bulk = 1'b1;
    while (req_rand || req_bulk)
    begin
      @(negedge INPUT_CLK);
      cycles++;
      if (cycles % REFRESH_GAP == 0)
        refresh_strobe = !refresh_strobe;
      if (grant_rand)
      begin
        left_rand--;
        if (left_rand > 0)
          next_access(addr_rand, we_rand);
        else
          req_rand = 1'b0;
      end
      if (grant_bulk)
      begin
        left_bulk--;
        if (left_bulk > 0)
          next_access(addr_bulk, we_bulk);
        else
          req_bulk = 1'b0;
      end
    end
  endtask

  task automatic wait_refresh_served();
    int waited;
    waited = 0;
    while (refresh_pending && waited <= REFRESH_LIMIT)
    begin
      @(negedge INPUT_CLK);
      waited++;
    end
  endtask

  task automatic refresh_idle();
    wait_refresh_served();  // Toggle from traffic may still be open
    @(negedge INPUT_CLK);
    refresh_strobe = !refresh_strobe;
    repeat (2) @(negedge INPUT_CLK);
    wait_refresh_served();
    repeat (30) @(negedge INPUT_CLK);
  endtask

  always @(posedge INPUT_CLK)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == CYCLE_LIMIT)
    begin
      $display("Run stopped at the cycle limit of %0d, an access was never granted",
               CYCLE_LIMIT);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  initial
  begin
    int errors_before;
    RST            = 1'b0;
    refresh_strobe = 1'b0;
    req_rand       = 1'b0;
    we_rand        = 1'b0;
    req_bulk       = 1'b0;
    we_bulk        = 1'b0;
    addr_rand      = '0;
    addr_bulk      = '0;
    rng_state      = 32'd92;
    repeat (3) @(posedge INPUT_CLK);
    @(negedge INPUT_CLK);
    RST = 1'b1;

    errors_before = error_count;
    reset_idle();
    finish_test("reset_idle", errors_before);

    errors_before = error_count;
    run_traffic(ACCESSES_PER_PORT);
    repeat (20) @(negedge INPUT_CLK);  // Catch late extra grants
    assert (grants_seen == accesses_driven)
      else report_mismatch("grants_seen", 32'(grants_seen), 32'(accesses_driven));
    finish_test("traffic", errors_before);

    errors_before = error_count;
    refresh_idle();
    finish_test("refresh_idle", errors_before);

    $display("Tests run %0d, errors %0d", test_count, error_count);
    if (error_count == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

//--- hw/sdram_cmd_top.sv
`timescale 1ns/1ns

module sdram_cmd_top
  import sdram_cmd_pkg::*;
(
  input  logic                   INPUT_CLK,
  input  logic                   RST,
  input  logic                   refresh_strobe,
  input  logic                   req_rand,
  input  logic                   we_rand,
  input  logic                   req_bulk,
  input  logic                   we_bulk,
  input  logic [HOST_ADDR_W-1:0] addr_rand,
  input  logic [HOST_ADDR_W-1:0] addr_bulk,
  output logic                   grant_rand,
  output logic                   grant_bulk,
  output cmd_t                   sd_cmd,
  output logic [SD_ADDR_W-1:0]   sd_addr,
  output logic [BANK_W-1:0]      sd_bank
);

  logic              hit_rand;
  logic              hit_bulk;
  logic              hit_any;
  logic              issue;
  cmd_t              issued_cmd;
  logic [PAGE_W-1:0] page_current;
  logic              slot_free;
  logic              page_active;
  logic              open_is_write;
  logic              open_is_rw;
  logic              refresh_time;
  logic              change_ok;
  logic              actv_done;

  page_match u_page_match (
    .INPUT_CLK    (INPUT_CLK),
    .RST          (RST),
    .req_rand     (req_rand),
    .req_bulk     (req_bulk),
    .addr_rand    (addr_rand),
    .addr_bulk    (addr_bulk),
    .refresh_time (refresh_time),
    .page_active  (page_active),
    .page_current (page_current),
    .hit_rand     (hit_rand),
    .hit_bulk     (hit_bulk),
    .hit_any      (hit_any)
  );

  timing_tracker u_timing_tracker (
    .INPUT_CLK      (INPUT_CLK),
    .RST            (RST),
    .refresh_strobe (refresh_strobe),
    .issue          (issue),
    .issued_cmd     (issued_cmd),
    .hit_any        (hit_any),
    .slot_free      (slot_free),
    .page_active    (page_active),
    .open_is_write  (open_is_write),
    .open_is_rw     (open_is_rw),
    .refresh_time   (refresh_time),
    .change_ok      (change_ok),
    .actv_done      (actv_done)
  );

  command_issue u_command_issue (
    .INPUT_CLK     (INPUT_CLK),
    .RST           (RST),
    .req_rand      (req_rand),
    .we_rand       (we_rand),
    .req_bulk      (req_bulk),
    .we_bulk       (we_bulk),
    .addr_rand     (addr_rand),
    .addr_bulk     (addr_bulk),
    .hit_rand      (hit_rand),
    .hit_bulk      (hit_bulk),
    .hit_any       (hit_any),
    .slot_free     (slot_free),
    .page_active   (page_active),
    .open_is_write (open_is_write),
    .open_is_rw    (open_is_rw),
    .refresh_time  (refresh_time),
    .change_ok     (change_ok),
    .actv_done     (actv_done),
    .sd_cmd        (sd_cmd),
    .sd_addr       (sd_addr),
    .sd_bank       (sd_bank),
    .grant_rand    (grant_rand),
    .grant_bulk    (grant_bulk),
    .issue         (issue),
    .issued_cmd    (issued_cmd),
    .page_current  (page_current)
  );

endmodule

//--- hw/command_issue.sv
`timescale 1ns/1ns

module command_issue
  import sdram_cmd_pkg::*;
(
  input  logic                   INPUT_CLK,
  input  logic                   RST,
  input  logic                   req_rand,
  input  logic                   we_rand,
  input  logic                   req_bulk,
  input  logic                   we_bulk,
  input  logic [HOST_ADDR_W-1:0] addr_rand,
  input  logic [HOST_ADDR_W-1:0] addr_bulk,
  input  logic                   hit_rand,
  input  logic                   hit_bulk,
  input  logic                   hit_any,
  input  logic                   slot_free,
  input  logic                   page_active,
  input  logic                   open_is_write,
  input  logic                   open_is_rw,
  input  logic                   refresh_time,
  input  logic                   change_ok,
  input  logic                   actv_done,
  output cmd_t                   sd_cmd,
  output logic [SD_ADDR_W-1:0]   sd_addr,
  output logic [BANK_W-1:0]      sd_bank,
  output logic                   grant_rand,
  output logic                   grant_bulk,
  output logic                   issue,
  output cmd_t                   issued_cmd,
  output logic [PAGE_W-1:0]      page_current
);

  logic                   req_rand_q;
  logic                   we_rand_q;
  logic                   req_bulk_q;
  logic                   we_bulk_q;
  logic [HOST_ADDR_W-1:0] addr_bulk_q;
  logic [HOST_ADDR_W-1:0] addr_sel;
  logic [ROW_W-1:0]       row_sel;
  logic                   write_match;
  logic                   on_page_ok;
  logic                   override_ok;
  logic                   is_prch;
  cmd_t                   cmd_non_rw;
  logic [SD_ADDR_W-1:0]   sd_addr_d;

  // ------------------------------
  // Issue decision
  // ------------------------------
  assign write_match = req_bulk_q ? we_bulk_q : (req_rand_q && we_rand_q);

  // Back to back on the open page, same direction only
  assign on_page_ok = slot_free && open_is_rw && (open_is_write == write_match);

  assign override_ok = slot_free && change_ok &&
                       (req_rand_q || req_bulk_q || refresh_time);

  assign issue = (hit_any && on_page_ok) || override_ok;

  always_comb
  begin
    if (page_active)
      cmd_non_rw = actv_done ? CMD_PRCH : CMD_NOOP;  // Row must settle first
    else if (refresh_time)
      cmd_non_rw = CMD_ARSR;
    else
      cmd_non_rw = CMD_ACTV;
  end

  assign issued_cmd = hit_any ? (write_match ? CMD_WRTE : CMD_READ) : cmd_non_rw;

  // ------------------------------
  // Address forming
  // ------------------------------
  assign addr_sel = req_bulk_q ? addr_bulk_q : addr_rand;
  assign row_sel  = addr_sel[HOST_ADDR_W-1:HOST_ADDR_W-ROW_W];
  assign is_prch  = page_active && !hit_any;

  always_comb
  begin
    if (is_prch)
      sd_addr_d = PRCH_ALL_ADDR;
    else if (hit_any)
      sd_addr_d = {addr_sel[COL_W-1:0], 1'b0};  // Column in 16-bit words
    else
      sd_addr_d = {row_sel[ROW_W-1:10], 1'b0, row_sel[9:0]};
  end

  always_ff @(posedge INPUT_CLK)
  begin
    addr_bulk_q <= addr_bulk;
  end

  always_ff @(posedge INPUT_CLK)
  begin
    if (!RST)
    begin
      req_rand_q   <= 1'b0;
      we_rand_q    <= 1'b0;
      req_bulk_q   <= 1'b0;
      we_bulk_q    <= 1'b0;
      sd_cmd       <= CMD_NOOP;
      sd_addr      <= PRCH_ALL_ADDR;
      sd_bank      <= '0;
      page_current <= '0;
      grant_rand   <= 1'b0;
      grant_bulk   <= 1'b0;
    end
    else
    begin
      req_rand_q <= req_rand;
      we_rand_q  <= we_rand;
      req_bulk_q <= req_bulk;
      we_bulk_q  <= we_bulk;

      sd_cmd  <= issue ? issued_cmd : CMD_NOOP;
      sd_addr <= sd_addr_d;

      // New page on ACTV, the ARSR update is harmless with no page open
      if (issue && !is_prch && !hit_any)
      begin
        page_current <= addr_sel[HOST_ADDR_W-1:COL_W];
        sd_bank      <= addr_sel[COL_W+BANK_W-1:COL_W];
      end

      grant_rand <= issue && hit_rand;
      grant_bulk <= issue && hit_bulk;
    end
  end

endmodule

//--- hw/timing_tracker.sv
`timescale 1ns/1ns

module timing_tracker
  import sdram_cmd_pkg::*;
(
  input  logic INPUT_CLK,
  input  logic RST,
  input  logic refresh_strobe,
  input  logic issue,
  input  cmd_t issued_cmd,
  input  logic hit_any,
  output logic slot_free,
  output logic page_active,
  output logic open_is_write,
  output logic open_is_rw,
  output logic refresh_time,
  output logic change_ok,
  output logic actv_done
);

  cmd_t                   cmd_latched;
  logic                   strobe_ack;
  logic                   extra_pass;
  logic                   change_n;
  logic                   change_next_n;
  logic                   done_norm;
  logic                   done_delay;
  logic [SPACE_CNT_W-1:0] space_cnt;
  logic [ACTV_WAIT_W-1:0] actv_wait;

  assign done_norm  = (space_cnt == SPACE_DONE_NORM_LO) ||
                      (space_cnt == SPACE_DONE_NORM_HI);
  assign done_delay = (space_cnt == SPACE_DONE_DELAY_LO) ||
                      (space_cnt == SPACE_DONE_DELAY_HI);

  assign change_ok = !change_n;
  assign actv_done = actv_wait[ACTV_WAIT_W-1];

  always_comb
  begin
    if (!slot_free)
      change_next_n = 1'b1;
    else if (hit_any)
      change_next_n = !done_norm;
    else if (extra_pass)
      change_next_n = 1'b1;  // Refresh takes a second lap
    else if (page_active && open_is_write)
      change_next_n = !done_delay;  // Write recovery before PRCH
    else
      change_next_n = !done_norm;
  end

  always_ff @(posedge INPUT_CLK)
  begin
    if (!RST)
    begin
      cmd_latched   <= CMD_NOOP;
      slot_free     <= 1'b1;
      page_active   <= 1'b0;
      open_is_write <= 1'b0;
      open_is_rw    <= 1'b0;
      refresh_time  <= 1'b0;
      strobe_ack    <= 1'b0;
      extra_pass    <= 1'b0;
      change_n      <= 1'b1;
      space_cnt     <= SPACE_IDLE;
      actv_wait     <= '1;
    end
    else
    begin
      cmd_latched  <= issue ? issued_cmd : CMD_NOOP;
      slot_free    <= !issue;  // Command slot, then forced NOOP
      refresh_time <= strobe_ack ^ refresh_strobe;

      if (!slot_free && cmd_latched == CMD_ACTV)
        actv_wait <= '0;
      else if (!actv_done)
        actv_wait <= actv_wait + ACTV_WAIT_W'(1);

      // ------------------------------
      // Bank state and spacing load
      // ------------------------------
      if (!slot_free)
      begin
        if (cmd_latched == CMD_ACTV)
          page_active <= 1'b1;
        if (cmd_latched == CMD_PRCH)
          page_active <= 1'b0;
        if (cmd_latched == CMD_WRTE)
          open_is_write <= 1'b1;
        else if (cmd_latched != CMD_NOOP)
          open_is_write <= 1'b0;
        if (cmd_latched == CMD_ARSR)
        begin
          strobe_ack <= refresh_strobe;  // Refresh served
          extra_pass <= 1'b1;
        end

        case (cmd_latched)
          CMD_ARSR: space_cnt <= SPACE_AFTER_ARSR;
          CMD_ACTV: space_cnt <= SPACE_AFTER_ACTV;
          CMD_NOOP: space_cnt <= SPACE_IDLE;
          default:  space_cnt <= SPACE_AFTER_RW;
        endcase
      end
      else
      begin
        space_cnt <= space_cnt + SPACE_CNT_W'(change_n);  // Holds once done
        if (space_cnt == '0)
          extra_pass <= 1'b0;
      end

      if (issue)
      begin
        change_n   <= 1'b1;
        open_is_rw <= hit_any;
      end
      else
        change_n <= change_next_n;
    end
  end

endmodule

//--- hw/page_match.sv
`timescale 1ns/1ns

module page_match
  import sdram_cmd_pkg::*;
(
  input  logic                   INPUT_CLK,
  input  logic                   RST,
  input  logic                   req_rand,
  input  logic                   req_bulk,
  input  logic [HOST_ADDR_W-1:0] addr_rand,
  input  logic [HOST_ADDR_W-1:0] addr_bulk,
  input  logic                   refresh_time,
  input  logic                   page_active,
  input  logic [PAGE_W-1:0]      page_current,
  output logic                   hit_rand,
  output logic                   hit_bulk,
  output logic                   hit_any
);

  logic [HOST_ADDR_W-1:0] addr_bulk_q;
  logic [PAGE_W-1:0]      page_rand;
  logic [PAGE_W-1:0]      page_bulk_live;
  logic [PAGE_W-1:0]      page_bulk_q;
  logic                   page_usable;
  logic                   hit_rand_d;
  logic                   hit_bulk_d;

  assign page_rand      = addr_rand[HOST_ADDR_W-1:COL_W];
  assign page_bulk_live = addr_bulk[HOST_ADDR_W-1:COL_W];
  assign page_bulk_q    = addr_bulk_q[HOST_ADDR_W-1:COL_W];

  // No hits while refresh waits, so the page gets closed
  assign page_usable = page_active && !refresh_time;

  // Bulk wins, random only hits on an idle bulk port
  assign hit_rand_d = req_rand && !req_bulk && page_usable &&
                      (page_rand == page_current);

  // Live page is checked too, so a new address right after a grant
  // is not taken for the old one
  assign hit_bulk_d = req_bulk && page_usable &&
                      (page_bulk_q == page_current) &&
                      (page_bulk_live == page_current);

  always_ff @(posedge INPUT_CLK)
  begin
    addr_bulk_q <= addr_bulk;
  end

  always_ff @(posedge INPUT_CLK)
  begin
    if (!RST)
    begin
      hit_rand <= 1'b0;
      hit_bulk <= 1'b0;
      hit_any  <= 1'b0;
    end
    else
    begin
      hit_rand <= hit_rand_d;
      hit_bulk <= hit_bulk_d;
      hit_any  <= hit_rand_d || hit_bulk_d;
    end
  end

endmodule

//--- hw/sdram_cmd_pkg.sv
package sdram_cmd_pkg;

  // ------------------------------
  // SDRAM command encoding
  // ------------------------------
  typedef enum logic [2:0] {
    CMD_MRST = 3'd0,  // Mode register set
    CMD_ARSR = 3'd1,  // Auto refresh
    CMD_PRCH = 3'd2,  // Row close
    CMD_ACTV = 3'd3,  // Row open
    CMD_WRTE = 3'd4,
    CMD_READ = 3'd5,
    CMD_BTRM = 3'd6,  // Burst terminate
    CMD_NOOP = 3'd7
  } cmd_t;

  // ------------------------------
  // Address fields
  // ------------------------------
  localparam int HOST_ADDR_W = 26;
  localparam int ROW_W       = 12;  // Bits 25..14
  localparam int BANK_W      = 2;   // Bits 13..12
  localparam int COL_W       = 12;  // Bits 11..0
  localparam int PAGE_W      = ROW_W + BANK_W;
  localparam int SD_ADDR_W   = 13;

  localparam logic [SD_ADDR_W-1:0] PRCH_ALL_ADDR = 13'h0400;  // A10 set

  // ------------------------------
  // Command spacing
  // ------------------------------
  localparam int SPACE_CNT_W = 4;

  localparam logic [SPACE_CNT_W-1:0] SPACE_AFTER_ARSR = 4'd3;
  localparam logic [SPACE_CNT_W-1:0] SPACE_AFTER_ACTV = 4'd12;
  localparam logic [SPACE_CNT_W-1:0] SPACE_AFTER_RW   = 4'd11;
  localparam logic [SPACE_CNT_W-1:0] SPACE_IDLE       = 4'd14;

  // Either value of a pair ends the wait
  localparam logic [SPACE_CNT_W-1:0] SPACE_DONE_NORM_LO  = 4'd13;
  localparam logic [SPACE_CNT_W-1:0] SPACE_DONE_NORM_HI  = 4'd14;
  localparam logic [SPACE_CNT_W-1:0] SPACE_DONE_DELAY_LO = 4'd14;
  localparam logic [SPACE_CNT_W-1:0] SPACE_DONE_DELAY_HI = 4'd15;

  localparam int ACTV_WAIT_W = 3;  // Top bit set when the wait is over

endpackage
